/* Makefile */
TOP := tb_exec_cluster

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): tb.f include/*.svh source/*.sv testbench/*.sv
	verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Finished with no errors"

lint:
	verilator --lint-only --timing -Wall -f tb.f --top-module $(TOP)

clean:
	rm -rf obj_dir

/* include/exec_config.svh */
`ifndef EXEC_CONFIG_SVH
`define EXEC_CONFIG_SVH

// operand and result width of the integer datapath.
`define EXEC_DATA_WIDTH 32

`define EXEC_REG_BITS 5 // 32 architectural registers.

`define EXEC_TAG_BITS 6

`endif

/* source/alu.sv */
`timescale 1ns/1ps
`include "exec_config.svh"

module alu (
    input  logic                          clk,
    input  logic                          rstn,
    input  logic                          en,
    input  exec_pkg::issue_t              issue,
    input  logic [`EXEC_DATA_WIDTH-1:0]   src_a,
    input  logic [`EXEC_DATA_WIDTH-1:0]   src_b,
    input  logic                          grant,
    output logic                          res_valid,
    output exec_pkg::wb_t                 res,
    output logic                          busy
);

    import exec_pkg::*;

    localparam int msb        = `EXEC_DATA_WIDTH - 1;
    localparam int shift_bits = $clog2(`EXEC_DATA_WIDTH);

    logic                  subtract;
    logic [msb:0]          adder_b;
    logic [msb:0]          sum;
    logic                  carry_out;
    logic                  less_signed;
    logic                  less_unsigned;
    logic [shift_bits-1:0] shamt;
    logic [msb:0]          result;

    // add, sub and both compares share one adder.
    assign subtract          = issue.op inside {op_sub, op_slt, op_sltu};
    assign adder_b           = subtract ? ~src_b : src_b;
    assign {carry_out, sum}  = src_a + adder_b + {{msb{1'b0}}, subtract};

    // operands of equal sign cannot overflow, so the difference sign decides.
    assign less_signed   = (src_a[msb] & ~src_b[msb]) |
                           (~(src_a[msb] ^ src_b[msb]) & sum[msb]);
    assign less_unsigned = ~carry_out; // a borrow means a < b.

    assign shamt = src_a[shift_bits-1:0]; // variable shifts take rs as the amount.

    always_comb begin
        case (issue.op)
            op_add, op_sub: result = sum;
            op_slt:         result = {{msb{1'b0}}, less_signed};
            op_sltu:        result = {{msb{1'b0}}, less_unsigned};
            op_and:         result = src_a & src_b;
            op_or:          result = src_a | src_b;
            op_nor:         result = ~(src_a | src_b);
            op_xor:         result = src_a ^ src_b;
            op_sll:         result = src_b << shamt;
            op_srl:         result = src_b >> shamt;
            op_sra:         result = $signed(src_b) >>> shamt;
            default:        result = '0;
        endcase
    end

    // a new issue wins over the grant, which is what allows reissue in the
    // cycle the previous result leaves.
    always_ff @(posedge clk) begin
        if (!rstn) begin
            res_valid <= 1'b0;
        end else if (en) begin
            res_valid <= 1'b1;
        end else if (grant) begin
            res_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (en) begin
            res.rd   <= issue.rd;
            res.tag  <= issue.tag;
            res.data <= result;
        end
    end

    assign busy = res_valid & ~grant;

    issue_while_busy: assert property (@(posedge clk) disable iff (!rstn) en |-> !busy)
        else $error("alu: issue while busy");

    legal_opcode: assert property (@(posedge clk) disable iff (!rstn)
        en |-> (issue.op inside {[op_add:op_sra]}))
        else $error("alu: illegal opcode %0d", issue.op);

endmodule

/* source/exec_cluster.sv */
`timescale 1ns/1ps
`include "exec_config.svh"

module exec_cluster (
    input  logic                clk,
    input  logic                rstn,
    input  logic                eu0_en,
    input  logic                eu1_en,
    input  exec_pkg::issue_t    eu0_issue,
    input  exec_pkg::issue_t    eu1_issue,
    output logic                eu0_busy,
    output logic                eu1_busy,
    output logic                wb_valid,
    output exec_pkg::wb_t       wb
);

    import exec_pkg::*;

    // read ports 0 and 1 serve eu0, ports 2 and 3 serve eu1.
    logic [3:0][`EXEC_DATA_WIDTH-1:0] rd_data;
    logic [1:0]                       res_valid;
    logic [1:0]                       grant;
    wb_t                              res0;
    wb_t                              res1;

    reg_file rf (
        .clk     (clk),
        .rstn    (rstn),
        .rd_addr ({eu1_issue.rt, eu1_issue.rs, eu0_issue.rt, eu0_issue.rs}),
        .rd_data (rd_data),
        .wr_en   (wb_valid),
        .wr      (wb)
    );

    alu eu0 (
        .clk       (clk),
        .rstn      (rstn),
        .en        (eu0_en),
        .issue     (eu0_issue),
        .src_a     (rd_data[0]),
        .src_b     (rd_data[1]),
        .grant     (grant[0]),
        .res_valid (res_valid[0]),
        .res       (res0),
        .busy      (eu0_busy)
    );

    alu eu1 (
        .clk       (clk),
        .rstn      (rstn),
        .en        (eu1_en),
        .issue     (eu1_issue),
        .src_a     (rd_data[2]),
        .src_b     (rd_data[3]),
        .grant     (grant[1]),
        .res_valid (res_valid[1]),
        .res       (res1),
        .busy      (eu1_busy)
    );

    // the bus doubles as the register file write port.
    wb_arbiter arb (
        .clk      (clk),
        .rstn     (rstn),
        .req      (res_valid),
        .res0     (res0),
        .res1     (res1),
        .grant    (grant),
        .wb_valid (wb_valid),
        .wb       (wb)
    );

endmodule

/* source/exec_pkg.sv */
`include "exec_config.svh"

package exec_pkg;

    // opcodes of one lane, in the order of the selector bits they replace.
    typedef enum logic [3:0] {
        op_add  = 4'd0,
        op_sub  = 4'd1,
        op_slt  = 4'd2,
        op_sltu = 4'd3,
        op_and  = 4'd4,
        op_or   = 4'd5,
        op_nor  = 4'd6,
        op_xor  = 4'd7,
        op_sll  = 4'd8,
        op_srl  = 4'd9,
        op_sra  = 4'd10
    } alu_op_e;

    // one micro-op as the issuer hands it to a lane.
    typedef struct packed {
        alu_op_e                   op;
        logic [`EXEC_REG_BITS-1:0] rs;
        logic [`EXEC_REG_BITS-1:0] rt;
        logic [`EXEC_REG_BITS-1:0] rd;
        logic [`EXEC_TAG_BITS-1:0] tag;
    } issue_t;

    // one result on its way to the register file.
    typedef struct packed {
        logic [`EXEC_REG_BITS-1:0]   rd;
        logic [`EXEC_TAG_BITS-1:0]   tag; // carried through for the issuer.
        logic [`EXEC_DATA_WIDTH-1:0] data;
    } wb_t;

endpackage

/* source/reg_file.sv */
`timescale 1ns/1ps
`include "exec_config.svh"

module reg_file (
    input  logic                                  clk,
    input  logic                                  rstn,
    input  logic [3:0][`EXEC_REG_BITS-1:0]        rd_addr,
    output logic [3:0][`EXEC_DATA_WIDTH-1:0]      rd_data,
    input  logic                                  wr_en,
    input  exec_pkg::wb_t                         wr
);

    localparam int num_regs = 1 << `EXEC_REG_BITS;

    // register 0 has no storage at all.
    logic [`EXEC_DATA_WIDTH-1:0] regs [1:num_regs-1];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 1; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr.rd != '0) begin
            regs[wr.rd] <= wr.data;
        end
    end

    // a lane reading the register that is on the write port this cycle
    // gets the new value, so back-to-back dependent issues need no stall.
    always_comb begin
        for (int p = 0; p < 4; p++) begin
            if (rd_addr[p] == '0) begin
                rd_data[p] = '0;
            end else if (wr_en && wr.rd == rd_addr[p]) begin
                rd_data[p] = wr.data;
            end else begin
                rd_data[p] = regs[rd_addr[p]];
            end
        end
    end

endmodule

/* source/wb_arbiter.sv */
`timescale 1ns/1ps
`include "exec_config.svh"

module wb_arbiter (
    input  logic            clk,
    input  logic            rstn,
    input  logic [1:0]      req,
    input  exec_pkg::wb_t   res0,
    input  exec_pkg::wb_t   res1,
    output logic [1:0]      grant,
    output logic            wb_valid,
    output exec_pkg::wb_t   wb
);

    logic last_eu1; // eu1 won the most recent grant.

    // on a tie the lane that did not win last time goes first.
    assign grant[0] = req[0] & (~req[1] | last_eu1);
    assign grant[1] = req[1] & (~req[0] | ~last_eu1);

    assign wb_valid = |req;
    assign wb       = grant[1] ? res1 : res0;

    // reset to eu1 so that eu0 takes the first tie.
    always_ff @(posedge clk) begin
        if (!rstn) begin
            last_eu1 <= 1'b1;
        end else if (|req) begin
            last_eu1 <= grant[1];
        end
    end

    grant_onehot: assert property (@(posedge clk) disable iff (!rstn) $onehot0(grant))
        else $error("wb_arbiter: grant %b is not one-hot", grant);

    grant_has_req: assert property (@(posedge clk) disable iff (!rstn)
        (grant & ~req) == 2'b00)
        else $error("wb_arbiter: grant %b without request %b", grant, req);

endmodule

/* tb.f */
+incdir+include
source/exec_pkg.sv
source/reg_file.sv
source/alu.sv
source/wb_arbiter.sv
source/exec_cluster.sv
testbench/tb_exec_cluster.sv

/* testbench/tb_exec_cluster.sv */
`timescale 1ns/1ps
`include "exec_config.svh"

module tb_exec_cluster;

    import exec_pkg::*;

    localparam int dw         = `EXEC_DATA_WIDTH;
    localparam int clk_period = 40;
    localparam int num_issues = 7 + 8 + 88 + 2 + 8 + 2; // per test, in run order.

    logic    clk;
    logic    rstn;
    logic    eu0_en;
    logic    eu1_en;
    issue_t  eu0_issue;
    issue_t  eu1_issue;
    logic    eu0_busy;
    logic    eu1_busy;
    logic    wb_valid;
    wb_t     wb;

    logic [dw-1:0]             ref_regs [0:31];
    logic [31:0]               rng_state;
    logic [`EXEC_TAG_BITS-1:0] next_tag;
    string                     test_name;

    exec_cluster dut0 (
        .clk       (clk),
        .rstn      (rstn),
        .eu0_en    (eu0_en),
        .eu1_en    (eu1_en),
        .eu0_issue (eu0_issue),
        .eu1_issue (eu1_issue),
        .eu0_busy  (eu0_busy),
        .eu1_busy  (eu1_busy),
        .wb_valid  (wb_valid),
        .wb        (wb)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // the model follows the bus, so it mirrors what the register file holds.
    always @(negedge clk) begin
        if (rstn && wb_valid && wb.rd != '0) begin
            ref_regs[wb.rd] <= wb.data;
        end
    end

    initial begin
        #((num_issues * 10 + 10) * clk_period);
        $display("watchdog expired before all tests completed");
        stop_run();
    end

    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic logic [dw-1:0] expected_result(alu_op_e op, logic [dw-1:0] a,
                                                      logic [dw-1:0] b);
        case (op)
            op_add:  return a + b;
            op_sub:  return a - b;
            op_slt:  return ($signed(a) < $signed(b)) ? 1 : 0;
            op_sltu: return (a < b) ? 1 : 0;
            op_and:  return a & b;
            op_or:   return a | b;
            op_nor:  return ~(a | b);
            op_xor:  return a ^ b;
            op_sll:  return b << a[4:0]; // shift amount comes from rs.
            op_srl:  return b >> a[4:0];
            op_sra:  return $signed(b) >>> a[4:0];
            default: return '0;
        endcase
    endfunction

    function automatic logic lane_busy(int lane);
        return (lane == 0) ? eu0_busy : eu1_busy;
    endfunction

    task automatic stop_run();
        $display("Finished with errors");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            $display("FAIL %s: %s expected %0h actual %0h", test_name, name, expected,
                     actual);
            stop_run();
        end
    endtask

    task automatic step();
        @(posedge clk);
        #2;
    endtask

    task automatic drive_issue(input int lane, input alu_op_e op, input logic [4:0] rs,
                               input logic [4:0] rt, input logic [4:0] rd,
                               input logic [`EXEC_TAG_BITS-1:0] tag);
        issue_t it;
        it.op  = op;
        it.rs  = rs;
        it.rt  = rt;
        it.rd  = rd;
        it.tag = tag;
        if (lane == 0) begin
            eu0_issue = it;
            eu0_en    = 1'b1;
        end else begin
            eu1_issue = it;
            eu1_en    = 1'b1;
        end
    endtask

    task automatic clear_issue();
        eu0_en = 1'b0;
        eu1_en = 1'b0;
    endtask

    task automatic wait_writeback(input logic [`EXEC_TAG_BITS-1:0] tag, output wb_t got);
        int cycles;
        cycles = 0;
        while (!(wb_valid && wb.tag == tag)) begin
            if (cycles == 20) begin
                $display("no writeback with tag %0d within 20 cycles", tag);
                stop_run();
            end else begin
                step();
                cycles++;
            end
        end
        got = wb;
    endtask

    task automatic run_op(input int lane, input alu_op_e op, input logic [4:0] rs,
                          input logic [4:0] rt, input logic [4:0] rd, input string name);
        logic [dw-1:0]             expected;
        logic [`EXEC_TAG_BITS-1:0] tag;
        wb_t                       got;
        expected = expected_result(op, ref_regs[rs], ref_regs[rt]);
        tag      = next_tag;
        next_tag = next_tag + 1'b1;
        check_value({name, " busy before issue"}, 0, lane_busy(lane));
        drive_issue(lane, op, rs, rt, rd, tag);
        step();
        clear_issue();
        wait_writeback(tag, got);
        check_value({name, " data"}, expected, got.data);
        check_value({name, " rd"}, rd, got.rd);
        step(); // the write lands at this edge.
    endtask

    task automatic issue_random(input int lane, output logic [dw-1:0] data,
                                output logic [`EXEC_TAG_BITS-1:0] tag, output logic [4:0] rd);
        alu_op_e    op;
        logic [4:0] rs;
        logic [4:0] rt;
        op       = alu_op_e'(next_rand() % 11);
        rs       = 5'(1 + next_rand() % 7);
        rt       = 5'(1 + next_rand() % 7);
        rd       = 5'(24 + next_rand() % 8);
        tag      = next_tag;
        next_tag = next_tag + 1'b1;
        data     = expected_result(op, ref_regs[rs], ref_regs[rt]);
        drive_issue(lane, op, rs, rt, rd, tag);
    endtask

    task automatic load_registers();
        logic [4:0] rs;
        logic [4:0] rt;
        test_name = "load_registers";
        run_op(0, op_nor, 5'd0, 5'd0, 5'd1, "load r1"); // all ones.
        run_op(1, op_sub, 5'd0, 5'd1, 5'd2, "load r2");
        run_op(0, op_add, 5'd2, 5'd2, 5'd3, "load r3");
        run_op(1, op_sll, 5'd1, 5'd2, 5'd4, "load r4");
        run_op(0, op_srl, 5'd3, 5'd1, 5'd5, "load r5");
        run_op(1, op_xor, 5'd4, 5'd5, 5'd6, "load r6");
        run_op(0, op_sra, 5'd2, 5'd4, 5'd7, "load r7");
        for (int r = 8; r < 16; r++) begin
            rs = 5'(1 + next_rand() % (r - 1));
            rt = 5'(1 + next_rand() % (r - 1));
            run_op(r % 2, (r % 2 == 1) ? op_nor : op_add, rs, rt, 5'(r), "load random");
        end
    endtask

    // rounds 0 and 1 pin operands with the sign bit set, the rest are random.
    task automatic each_op();
        logic [4:0] rs;
        logic [4:0] rt;
        alu_op_e    op;
        test_name = "each_op";
        for (int round = 0; round < 4; round++) begin
            rs = (round == 0) ? 5'd4 : (round == 1) ? 5'd6 : 5'(1 + next_rand() % 15);
            rt = (round == 0) ? 5'd2 : (round == 1) ? 5'd7 : 5'(1 + next_rand() % 15);
            for (int lane = 0; lane < 2; lane++) begin
                for (int k = 0; k < 11; k++) begin
                    op = alu_op_e'(k);
                    run_op(lane, op, rs, rt, 5'(16 + next_rand() % 16),
                           $sformatf("each_op %s lane %0d", op.name(), lane));
                end
            end
        end
    endtask

    task automatic register_zero();
        test_name = "register_zero";
        run_op(0, op_add, 5'd2, 5'd3, 5'd0, "r0 write"); // still shows on the bus.
        run_op(1, op_or, 5'd0, 5'd0, 5'd20, "r0 read");
    endtask

    task automatic contention();
        logic [dw-1:0]             pend_data [2];
        logic [`EXEC_TAG_BITS-1:0] pend_tag [2];
        logic [4:0]                pend_rd [2];
        int                        win;
        test_name = "contention";
        // eu1 holds the last grant, so eu0 must take the first tie.
        run_op(1, op_or, 5'd1, 5'd2, 5'd24, "contention setup");
        for (int l = 0; l < 2; l++) begin
            issue_random(l, pend_data[l], pend_tag[l], pend_rd[l]);
        end
        step();
        clear_issue();
        win = 0;
        for (int k = 0; k < 6; k++) begin
            check_value("contention valid", 1, wb_valid);
            check_value("contention tag", pend_tag[win], wb.tag);
            check_value("contention data", pend_data[win], wb.data);
            check_value("contention rd", pend_rd[win], wb.rd);
            check_value("contention loser busy", 1, lane_busy(1 - win));
            check_value("contention winner busy", 0, lane_busy(win));
            if (k < 5) begin
                issue_random(win, pend_data[win], pend_tag[win], pend_rd[win]);
            end
            step();
            clear_issue();
            win = 1 - win;
        end
        check_value("contention drain valid", 1, wb_valid);
        check_value("contention drain tag", pend_tag[win], wb.tag);
        check_value("contention drain data", pend_data[win], wb.data);
        check_value("contention drain busy", 0, lane_busy(win));
        step();
    endtask

    task automatic forwarding();
        logic [dw-1:0] new_val;
        logic [dw-1:0] fwd_val;
        test_name = "forwarding";
        // the producer inverts r10, so the stored value can never stand in for the new one.
        new_val = expected_result(op_nor, ref_regs[10], ref_regs[0]);
        fwd_val = expected_result(op_sub, new_val, ref_regs[2]);
        drive_issue(0, op_nor, 5'd10, 5'd0, 5'd10, 6'd50);
        step();
        clear_issue();
        check_value("forward producer valid", 1, wb_valid);
        check_value("forward producer tag", 50, wb.tag);
        check_value("forward producer data", new_val, wb.data);
        // r10 sits on the write port right now.
        drive_issue(1, op_sub, 5'd10, 5'd2, 5'd11, 6'd51);
        step();
        clear_issue();
        check_value("forward consumer valid", 1, wb_valid);
        check_value("forward consumer tag", 51, wb.tag);
        check_value("forward consumer data", fwd_val, wb.data);
        step();
    endtask

    initial begin
        rng_state = 32'd24983;
        next_tag  = '0;
        test_name = "reset";
        for (int i = 0; i < 32; i++) begin
            ref_regs[i] = '0;
        end
        rstn      = 1'b0;
        eu0_en    = 1'b0;
        eu1_en    = 1'b0;
        eu0_issue = '0;
        eu1_issue = '0;
        repeat (10) @(posedge clk);
        #2;
        rstn = 1'b1;
        check_value("reset wb_valid", 0, wb_valid);
        check_value("reset eu0_busy", 0, eu0_busy);
        check_value("reset eu1_busy", 0, eu1_busy);
        load_registers();
        each_op();
        register_zero();
        contention();
        forwarding();
        $display("Finished with no errors");
        $finish;
    end

endmodule
